// File: io_subsystem_top.f
src/io_pkg.sv
src/endpoint_fifo.sv
src/io_bus.sv
src/display.sv
src/io_subsystem_top.sv
testbench/tb_clock.sv
testbench/io_checker.sv
testbench/tb_io_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
# Build the I/O subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
   --top-module tb_io_subsystem \
   -f io_subsystem_top.f

sim_out=$(./obj_dir/Vtb_io_subsystem)
echo "$sim_out"

if grep -q "^Regression passed$" <<< "$sim_out"; then
   exit 0
fi
exit 1

// File: src/display.sv
/* Display registers on the I/O bus
 * Hex digit, green and red LED registers, write only
 * Seven-segment decoding into registered outputs, assertions
 */

`timescale 1ns/1ps

module display import io_pkg::*; (
   input  logic       clk,
   input  logic       rst_n_i,
   input  io_req_t    io_req_i,                     // Shared processor bus
   output logic [6:0] hex0_o,                       // Digit 0, bits 3:0
   output logic [6:0] hex1_o,
   output logic [6:0] hex2_o,
   output logic [6:0] hex3_o,                       // Digit 3, bits 15:12
   output logic [7:0] ledg_o,                       // Green LEDs
   output logic [9:0] ledr_o                        // Red LEDs
);

   logic [15:0] hex_q;                              // Four nibbles on display
   logic [15:0] hex_d;
   logic        wr_hex;
   logic        wr_ledg;
   logic        wr_ledr;
   logic [6:0]  seg_q [4];                          // Registered segment patterns

   assign wr_hex  = io_req_i.wr && (io_req_i.addr == ADDR_HEX);
   assign wr_ledg = io_req_i.wr && (io_req_i.addr == ADDR_LEDG);
   assign wr_ledr = io_req_i.wr && (io_req_i.addr == ADDR_LEDR);

   // Decode from the next value so digits change one cycle after wr
   assign hex_d = wr_hex ? io_req_i.dout : hex_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         hex_q  <= 16'h0000;
         ledg_o <= 8'h00;                           // LEDs off
         ledr_o <= 10'h000;
      end else begin
         hex_q <= hex_d;
         if (wr_ledg) begin
            ledg_o <= io_req_i.dout[7:0];
         end
         if (wr_ledr) begin
            ledr_o <= io_req_i.dout[9:0];
         end
      end
   end

   for (genvar i = 0; i < 4; i++) begin : g_digit
      always_ff @(posedge clk) begin
         if (!rst_n_i) begin
            seg_q[i] <= seg_font(4'h0);             // Glyph 0 after reset
         end else begin
            seg_q[i] <= seg_font(hex_d[4*i +: 4]);
         end
      end
   end

   assign hex0_o = seg_q[0];
   assign hex1_o = seg_q[1];
   assign hex2_o = seg_q[2];
   assign hex3_o = seg_q[3];

   // Processor issues at most one strobe per cycle
   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(io_req_i.rd && io_req_i.wr))
      else $error("display saw rd and wr together");

endmodule

// File: src/endpoint_fifo.sv
/* Endpoint byte FIFO
 * Synchronous circular buffer, first-word fall-through
 * Full and empty flags, occupancy assertions
 */

`timescale 1ns/1ps

module endpoint_fifo import io_pkg::*; #(
   parameter int unsigned FIFO_DEPTH = 8            // Power of two
) (
   input  logic       clk,
   input  logic       rst_n_i,
   input  fifo_push_t push_i,                       // Producer side
   input  logic       rd_i,                         // Pop strobe from consumer
   output fifo_stat_t stat_o                        // Head byte and flags
);

   localparam int unsigned AW = $clog2(FIFO_DEPTH);

   logic [7:0]  mem [FIFO_DEPTH];                   // Storage, no reset
   logic [AW:0] wr_ptr;                             // Extra bit tells full from empty
   logic [AW:0] rd_ptr;
   logic [AW:0] count;                              // Occupancy
   logic        empty;
   logic        full;
   logic        do_push;
   logic        do_pop;

   assign empty   = (wr_ptr == rd_ptr);
   assign full    = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign count   = wr_ptr - rd_ptr;
   assign do_push = push_i.wr && !full;             // Push into full FIFO dropped
   assign do_pop  = rd_i && !empty;                 // Pop from empty FIFO ignored

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[AW-1:0]] <= push_i.data;
      end
   end

   // Head is visible without a pop, next byte after each pop edge
   assign stat_o.data  = mem[rd_ptr[AW-1:0]];
   assign stat_o.empty = empty;
   assign stat_o.full  = full;

   // Pointers never drift more than one buffer apart
   a_occupancy: assert property (@(posedge clk) disable iff (!rst_n_i)
      count <= FIFO_DEPTH)
      else $error("endpoint_fifo occupancy %0d above depth", count);

   a_flags: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(empty && full))
      else $error("endpoint_fifo empty and full together");

endmodule

// File: src/io_bus.sv
/* I/O bus decoder
 * Key, switch and status reads, registered read data
 * Push strobes for the in endpoints, pop strobe for endpoint 0 out
 */

`timescale 1ns/1ps

module io_bus import io_pkg::*; #(
   parameter int unsigned FIFO_DEPTH = 8            // Depth of the endpoint FIFOs
) (
   input  logic        clk,
   input  logic        rst_n_i,
   input  io_req_t     io_req_i,                    // Processor bus request
   input  logic [3:0]  key_i,                       // Push buttons
   input  logic [9:0]  sw_i,                        // Slide switches
   output logic [15:0] io_din_o,                    // Read data, one cycle after rd
   output fifo_push_t  ep0i_push_o,                 // Bus writes into endpoint 0 in
   output fifo_push_t  ep1i_push_o,                 // Bus writes into endpoint 1 in
   output logic        ep0o_rd_o,                   // Bus read pops endpoint 0 out
   input  fifo_stat_t  ep0o_stat_i,
   input  fifo_stat_t  ep0i_stat_i,
   input  fifo_stat_t  ep1i_stat_i
);

   logic        sel_ep0i;
   logic        sel_ep0o;
   logic        sel_ep1i;
   logic [15:0] rdata;                              // Read mux output
   logic [15:0] stat_word;

   assign sel_ep0i = (io_req_i.addr == ADDR_EP0I);
   assign sel_ep0o = (io_req_i.addr == ADDR_EP0O);
   assign sel_ep1i = (io_req_i.addr == ADDR_EP1I);

   // Low byte of the write data goes to the FIFO
   assign ep0i_push_o.wr   = io_req_i.wr && sel_ep0i;
   assign ep0i_push_o.data = io_req_i.dout[7:0];
   assign ep1i_push_o.wr   = io_req_i.wr && sel_ep1i;
   assign ep1i_push_o.data = io_req_i.dout[7:0];

   // Pop at the edge that ends the rd cycle, head sampled at the same edge
   assign ep0o_rd_o = io_req_i.rd && sel_ep0o && !ep0o_stat_i.empty;

   assign stat_word = {13'h0000,
                       ep1i_stat_i.full,            // Bit 2
                       ep0o_stat_i.empty,           // Bit 1
                       ep0i_stat_i.full};           // Bit 0

   always_comb begin
      rdata = 16'h0000;                             // Unmapped and display reads
      case (io_req_i.addr)
         ADDR_KEY:  rdata = {12'h000, key_i};
         ADDR_SW:   rdata = {6'h00, sw_i};
         ADDR_EP0O: begin
            if (!ep0o_stat_i.empty) begin
               rdata = {8'h00, ep0o_stat_i.data};   // Empty FIFO reads as 0
            end
         end
         ADDR_STAT: rdata = stat_word;
         default:   rdata = 16'h0000;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         io_din_o <= 16'h0000;
      end else begin
         io_din_o <= io_req_i.rd ? rdata : 16'h0000; // Zero after non-read cycles
      end
   end

   // Pointer wrap in the FIFOs needs a power-of-two depth
   a_depth: assert property (@(posedge clk)
      FIFO_DEPTH >= 2 && (FIFO_DEPTH & (FIFO_DEPTH - 1)) == 0)
      else $error("io_bus FIFO_DEPTH %0d not a power of two", FIFO_DEPTH);

   // Accepted bus push makes endpoint 0 in non-empty one cycle later
   a_ep0i_push: assert property (@(posedge clk) disable iff (!rst_n_i)
      ep0i_push_o.wr && !ep0i_stat_i.full |=> !ep0i_stat_i.empty)
      else $error("io_bus push into endpoint 0 in not visible");

endmodule

// File: src/io_pkg.sv
/* Shared definitions of the I/O subsystem
 * Processor bus request and endpoint FIFO structs
 * I/O address map
 * Seven-segment font function
 */

package io_pkg;

   // Processor I/O bus request, one strobe per cycle
   typedef struct packed {
      logic        rd;           // Read strobe
      logic        wr;           // Write strobe
      logic [15:0] addr;         // I/O address
      logic [15:0] dout;         // Write data from processor
   } io_req_t;

   // Push side of an endpoint FIFO
   typedef struct packed {
      logic       wr;            // Push strobe
      logic [7:0] data;          // Byte to push
   } fifo_push_t;

   // FIFO state as seen by the consumer
   typedef struct packed {
      logic [7:0] data;          // Head byte, first-word fall-through
      logic       empty;
      logic       full;
   } fifo_stat_t;

   // Address map
   localparam logic [15:0] ADDR_KEY  = 16'h1000; // Push buttons
   localparam logic [15:0] ADDR_SW   = 16'h1001; // Slide switches
   localparam logic [15:0] ADDR_HEX  = 16'h2000; // Four hex digits
   localparam logic [15:0] ADDR_LEDG = 16'h2001; // Green LEDs
   localparam logic [15:0] ADDR_LEDR = 16'h2002; // Red LEDs
   localparam logic [15:0] ADDR_EP0I = 16'h3000; // Endpoint 0 in, write only
   localparam logic [15:0] ADDR_EP0O = 16'h3001; // Endpoint 0 out, read pops
   localparam logic [15:0] ADDR_EP1I = 16'h3002; // Endpoint 1 in, write only
   localparam logic [15:0] ADDR_STAT = 16'h3003; // Endpoint flags

   // Active-low segments, bit order gfedcba
   function automatic logic [6:0] seg_font(input logic [3:0] nib);
      case (nib)
         4'h0: seg_font = 7'b1000000;
         4'h1: seg_font = 7'b1111001;
         4'h2: seg_font = 7'b0100100;
         4'h3: seg_font = 7'b0110000;
         4'h4: seg_font = 7'b0011001;
         4'h5: seg_font = 7'b0010010;
         4'h6: seg_font = 7'b0000010;
         4'h7: seg_font = 7'b1111000;
         4'h8: seg_font = 7'b0000000;
         4'h9: seg_font = 7'b0010000;
         4'ha: seg_font = 7'b0001000;
         4'hb: seg_font = 7'b0000011; // Lower case b
         4'hc: seg_font = 7'b1000110;
         4'hd: seg_font = 7'b0100001; // Lower case d
         4'he: seg_font = 7'b0000110;
         default: seg_font = 7'b0001110; // F
      endcase
   endfunction

endpackage

// File: src/io_subsystem_top.sv
/* I/O subsystem top level
 * Bus decoder, three endpoint FIFOs and display
 */

`timescale 1ns/1ps

module io_subsystem_top import io_pkg::*; #(
   parameter int unsigned FIFO_DEPTH = 8            // Depth of every endpoint FIFO
) (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic [3:0]  key_i,
   input  logic [9:0]  sw_i,
   input  io_req_t     io_req_i,                    // Processor bus
   output logic [15:0] io_din_o,
   input  logic        ep0i_rd_i,                   // USB pops endpoint 0 in
   output logic [7:0]  ep0i_data_o,
   output logic        ep0i_empty_o,
   input  fifo_push_t  ep0o_push_i,                 // USB pushes endpoint 0 out
   output logic        ep0o_full_o,
   input  logic        ep1i_rd_i,                   // USB pops endpoint 1 in
   output logic [7:0]  ep1i_data_o,
   output logic        ep1i_empty_o,
   output logic [6:0]  hex0_o,
   output logic [6:0]  hex1_o,
   output logic [6:0]  hex2_o,
   output logic [6:0]  hex3_o,
   output logic [7:0]  ledg_o,
   output logic [9:0]  ledr_o
);

   fifo_push_t ep0i_push;                           // Bus side pushes
   fifo_push_t ep1i_push;
   logic       ep0o_rd;                             // Bus side pop
   fifo_stat_t ep0i_stat;
   fifo_stat_t ep0o_stat;
   fifo_stat_t ep1i_stat;

   io_bus #(.FIFO_DEPTH(FIFO_DEPTH)) u_io_bus (
      .clk(clk), .rst_n_i(rst_n_i), .io_req_i(io_req_i),
      .key_i(key_i), .sw_i(sw_i), .io_din_o(io_din_o),
      .ep0i_push_o(ep0i_push), .ep1i_push_o(ep1i_push), .ep0o_rd_o(ep0o_rd),
      .ep0o_stat_i(ep0o_stat), .ep0i_stat_i(ep0i_stat), .ep1i_stat_i(ep1i_stat));

   endpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_ep0i (
      .clk(clk), .rst_n_i(rst_n_i), .push_i(ep0i_push),
      .rd_i(ep0i_rd_i), .stat_o(ep0i_stat));

   endpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_ep0o (
      .clk(clk), .rst_n_i(rst_n_i), .push_i(ep0o_push_i),
      .rd_i(ep0o_rd), .stat_o(ep0o_stat));

   endpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_ep1i (
      .clk(clk), .rst_n_i(rst_n_i), .push_i(ep1i_push),
      .rd_i(ep1i_rd_i), .stat_o(ep1i_stat));

   display u_display (
      .clk(clk), .rst_n_i(rst_n_i), .io_req_i(io_req_i),
      .hex0_o(hex0_o), .hex1_o(hex1_o), .hex2_o(hex2_o), .hex3_o(hex3_o),
      .ledg_o(ledg_o), .ledr_o(ledr_o));

   // USB side views of the endpoint FIFOs
   assign ep0i_data_o  = ep0i_stat.data;
   assign ep0i_empty_o = ep0i_stat.empty;
   assign ep0o_full_o  = ep0o_stat.full;
   assign ep1i_data_o  = ep1i_stat.data;
   assign ep1i_empty_o = ep1i_stat.empty;

endmodule

// File: testbench/io_checker.sv
/* Scoreboard for the I/O subsystem
 * Queue models of the endpoint FIFOs, display register model
 * Compares read data, FIFO flags and heads, display outputs every cycle
 */

`timescale 1ns/1ps

module io_checker import io_pkg::*; #(
   parameter int unsigned FIFO_DEPTH = 8
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  io_req_t     io_req_i,                    // Bus request seen by the DUT
   input  logic [3:0]  key_i,
   input  logic [9:0]  sw_i,
   input  logic        ep0i_rd_i,                   // USB-side pops
   input  logic        ep1i_rd_i,
   input  fifo_push_t  ep0o_push_i,                 // USB-side push
   input  logic [15:0] io_din_i,                    // DUT outputs from here on
   input  logic [7:0]  ep0i_data_i,
   input  logic        ep0i_empty_i,
   input  logic        ep0o_full_i,
   input  logic [7:0]  ep1i_data_i,
   input  logic        ep1i_empty_i,
   input  logic [6:0]  hex0_i,
   input  logic [6:0]  hex1_i,
   input  logic [6:0]  hex2_i,
   input  logic [6:0]  hex3_i,
   input  logic [7:0]  ledg_i,
   input  logic [9:0]  ledr_i,
   output int          checks_o,
   output int          errors_o
);

   logic [7:0]  q_ep0i [$];                         // Bytes waiting in each endpoint
   logic [7:0]  q_ep0o [$];
   logic [7:0]  q_ep1i [$];
   logic [15:0] hex_m;                              // Display registers
   logic [7:0]  ledg_m;
   logic [9:0]  ledr_m;
   logic [15:0] exp_din;                            // Answer to the last read request
   int          checks = 0;
   int          errors = 0;

   assign checks_o = checks;
   assign errors_o = errors;

   // Active-low glyph built from the lit segments a to g
   function automatic logic [6:0] glyph(input logic [3:0] nib);
      string      lit;
      logic [6:0] seg;
      logic [2:0] idx;
      case (nib)
         4'h0: lit = "abcdef";
         4'h1: lit = "bc";
         4'h2: lit = "abdeg";
         4'h3: lit = "abcdg";
         4'h4: lit = "bcfg";
         4'h5: lit = "acdfg";
         4'h6: lit = "acdefg";
         4'h7: lit = "abc";
         4'h8: lit = "abcdefg";
         4'h9: lit = "abcdfg";
         4'ha: lit = "abcefg";
         4'hb: lit = "cdefg";
         4'hc: lit = "adef";
         4'hd: lit = "bcdeg";
         4'he: lit = "adefg";
         default: lit = "aefg";
      endcase
      seg = 7'h7f;                                  // All segments dark
      for (int i = 0; i < lit.len(); i++) begin
         idx = 3'(int'(lit[i]) - 97);               // Segment a is bit 0
         seg[idx] = 1'b0;
      end
      return seg;
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic compare_outputs();
      check_value("io_din_o", io_din_i, exp_din);
      check_value("ep0i_empty_o", 16'(ep0i_empty_i), 16'(q_ep0i.size() == 0));
      check_value("ep1i_empty_o", 16'(ep1i_empty_i), 16'(q_ep1i.size() == 0));
      check_value("ep0o_full_o", 16'(ep0o_full_i), 16'(q_ep0o.size() == FIFO_DEPTH));
      if (q_ep0i.size() != 0) begin
         check_value("ep0i_data_o", 16'(ep0i_data_i), 16'(q_ep0i[0])); // Head only
      end
      if (q_ep1i.size() != 0) begin
         check_value("ep1i_data_o", 16'(ep1i_data_i), 16'(q_ep1i[0]));
      end
      check_value("hex0_o", 16'(hex0_i), 16'(glyph(hex_m[3:0])));
      check_value("hex1_o", 16'(hex1_i), 16'(glyph(hex_m[7:4])));
      check_value("hex2_o", 16'(hex2_i), 16'(glyph(hex_m[11:8])));
      check_value("hex3_o", 16'(hex3_i), 16'(glyph(hex_m[15:12])));
      check_value("ledg_o", 16'(ledg_i), 16'(ledg_m));
      check_value("ledr_o", 16'(ledr_i), 16'(ledr_m));
   endtask

   task automatic update_model();
      logic ep0i_full;
      logic ep1i_full;
      logic ep0o_full;
      logic ep0o_empty;
      logic pop_ep0o;
      ep0i_full  = (q_ep0i.size() == FIFO_DEPTH);   // Flags as they stood before the edge
      ep1i_full  = (q_ep1i.size() == FIFO_DEPTH);
      ep0o_full  = (q_ep0o.size() == FIFO_DEPTH);
      ep0o_empty = (q_ep0o.size() == 0);
      pop_ep0o   = 1'b0;
      exp_din    = 16'h0000;                        // Zero unless a mapped read
      if (io_req_i.rd) begin
         case (io_req_i.addr)
            ADDR_KEY:  exp_din = {12'h000, key_i};
            ADDR_SW:   exp_din = {6'h00, sw_i};
            ADDR_STAT: exp_din = {13'h0000, ep1i_full, ep0o_empty, ep0i_full};
            ADDR_EP0O: begin
               if (!ep0o_empty) begin
                  exp_din  = {8'h00, q_ep0o[0]};
                  pop_ep0o = 1'b1;
               end
            end
            default:   exp_din = 16'h0000;
         endcase
      end
      // Pops first, pushes judged on the old full flag
      if (ep0i_rd_i && q_ep0i.size() != 0) begin
         void'(q_ep0i.pop_front());
      end
      if (ep1i_rd_i && q_ep1i.size() != 0) begin
         void'(q_ep1i.pop_front());
      end
      if (pop_ep0o) begin
         void'(q_ep0o.pop_front());
      end
      if (ep0o_push_i.wr && !ep0o_full) begin
         q_ep0o.push_back(ep0o_push_i.data);
      end
      if (io_req_i.wr) begin
         case (io_req_i.addr)
            ADDR_EP0I: if (!ep0i_full) q_ep0i.push_back(io_req_i.dout[7:0]); // Else lost
            ADDR_EP1I: if (!ep1i_full) q_ep1i.push_back(io_req_i.dout[7:0]);
            ADDR_HEX:  hex_m  = io_req_i.dout;
            ADDR_LEDG: ledg_m = io_req_i.dout[7:0];
            ADDR_LEDR: ledr_m = io_req_i.dout[9:0];
            default:   ;
         endcase
      end
   endtask

   // Values sampled at the edge are the ones of the cycle just ending
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         q_ep0i.delete();
         q_ep0o.delete();
         q_ep1i.delete();
         hex_m   = 16'h0000;
         ledg_m  = 8'h00;
         ledr_m  = 10'h000;
         exp_din = 16'h0000;
      end else begin
         compare_outputs();
         update_model();
      end
   end

endmodule

// File: testbench/tb_clock.sv
/* Testbench clock source
 * Free-running clock, 8 ns period by default
 */

`timescale 1ns/1ps

module tb_clock #(
   parameter int unsigned PERIOD_NS = 8             // Full clock period
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2) clk_o = ~clk_o;          // Half period per phase

endmodule

// File: testbench/tb_io_subsystem.sv
/* Testbench top for the I/O subsystem
 * Clock, reset, LFSR-driven bus and USB-side stimulus
 * Cycle timeout and closing report from the scoreboard counts
 */

`timescale 1ns/1ps

module tb_io_subsystem import io_pkg::*; ();

   localparam int unsigned FIFO_DEPTH = 8;
   localparam int          NUM_CYCLES = 3000;      // Random test cycles
   localparam int          MAX_CYCLES = NUM_CYCLES + 200; // Reset, drain and margin

   logic        clk;
   logic        rst_n;
   io_req_t     io_req;
   logic [3:0]  key;
   logic [9:0]  sw;
   logic        ep0i_rd;
   logic        ep1i_rd;
   fifo_push_t  ep0o_push;
   logic [15:0] io_din;
   logic [7:0]  ep0i_data;
   logic        ep0i_empty;
   logic        ep0o_full;
   logic [7:0]  ep1i_data;
   logic        ep1i_empty;
   logic [6:0]  hex0;
   logic [6:0]  hex1;
   logic [6:0]  hex2;
   logic [6:0]  hex3;
   logic [7:0]  ledg;
   logic [9:0]  ledr;
   int          checks;
   int          errors;
   int          cycle_cnt = 0;
   logic [31:0] lfsr_state;

   tb_clock #(.PERIOD_NS(8)) u_clock (.clk_o(clk));

   io_subsystem_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
      .clk(clk), .rst_n_i(rst_n), .key_i(key), .sw_i(sw),
      .io_req_i(io_req), .io_din_o(io_din),
      .ep0i_rd_i(ep0i_rd), .ep0i_data_o(ep0i_data), .ep0i_empty_o(ep0i_empty),
      .ep0o_push_i(ep0o_push), .ep0o_full_o(ep0o_full),
      .ep1i_rd_i(ep1i_rd), .ep1i_data_o(ep1i_data), .ep1i_empty_o(ep1i_empty),
      .hex0_o(hex0), .hex1_o(hex1), .hex2_o(hex2), .hex3_o(hex3),
      .ledg_o(ledg), .ledr_o(ledr));

   io_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_checker (
      .clk_i(clk), .rst_n_i(rst_n), .io_req_i(io_req), .key_i(key), .sw_i(sw),
      .ep0i_rd_i(ep0i_rd), .ep1i_rd_i(ep1i_rd), .ep0o_push_i(ep0o_push),
      .io_din_i(io_din), .ep0i_data_i(ep0i_data), .ep0i_empty_i(ep0i_empty),
      .ep0o_full_i(ep0o_full), .ep1i_data_i(ep1i_data), .ep1i_empty_i(ep1i_empty),
      .hex0_i(hex0), .hex1_i(hex1), .hex2_i(hex2), .hex3_i(hex3),
      .ledg_i(ledg), .ledr_i(ledr), .checks_o(checks), .errors_o(errors));

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);        // One step per bit
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   // FIFO ports weighted up so the queues fill and drain
   function automatic logic [15:0] mapped_addr(input logic [3:0] idx);
      case (idx)
         4'd0:                return ADDR_KEY;
         4'd1:                return ADDR_SW;
         4'd2:                return ADDR_HEX;
         4'd3:                return ADDR_LEDG;
         4'd4:                return ADDR_LEDR;
         4'd5, 4'd6, 4'd7:    return ADDR_EP0I;
         4'd8, 4'd9, 4'd10:   return ADDR_EP0O;
         4'd11, 4'd12, 4'd13: return ADDR_EP1I;
         default:             return ADDR_STAT;
      endcase
   endfunction

   task automatic drive_cycle(input int n);
      logic [31:0] r;
      io_req_t     req;
      logic        fill;
      fill = !n[8];                                 // 256-cycle fill and drain phases
      req  = '0;
      draw_bits(4, r);
      req.addr = mapped_addr(r[3:0]);
      if (r[3:0] == 4'hf) begin
         draw_bits(16, r);                          // Mostly unmapped address
         req.addr = r[15:0];
      end
      draw_bits(16, r);
      req.dout = r[15:0];
      draw_bits(3, r);
      req.rd = (r[2:0] < 3'd3);
      req.wr = (r[2:0] >= 3'd3) && (r[2:0] < 3'd6); // Rest are idle cycles
      io_req <= req;
      draw_bits(5, r);
      ep0i_rd <= fill ? (r[4:0] == 5'd0) : r[0];
      draw_bits(5, r);
      ep1i_rd <= fill ? (r[4:0] == 5'd0) : r[0];
      draw_bits(5, r);
      ep0o_push.wr <= fill ? r[0] : (r[4:0] == 5'd0);
      draw_bits(8, r);
      ep0o_push.data <= r[7:0];
      draw_bits(4, r);
      key <= r[3:0];
      draw_bits(10, r);
      sw <= r[9:0];
   endtask

   initial begin
      lfsr_state = 32'h8214;
      rst_n      = 1'b0;
      io_req     = '0;
      key        = 4'h0;
      sw         = 10'h000;
      ep0i_rd    = 1'b0;
      ep1i_rd    = 1'b0;
      ep0o_push  = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      for (int n = 0; n < NUM_CYCLES; n++) begin
         drive_cycle(n);
         @(posedge clk);
      end
      io_req    <= '0;                              // Quiet bus so last results get checked
      ep0i_rd   <= 1'b0;
      ep1i_rd   <= 1'b0;
      ep0o_push <= '0;
      repeat (3) @(posedge clk);
      @(negedge clk);                               // Scoreboard done with the last edge
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: stimulus still running after %0d cycles", cycle_cnt);
         $display("Regression failed");
         $finish;
      end
   end

endmodule
